// File: files.f
+incdir+src
src/cache_pkg.sv
src/mem_pkg.sv
src/tag_cam.sv
src/buffer_fifo.sv
src/cache_line_ram.sv
src/cache_controller.sv
src/cache_top.sv
tb/cache_checker.sv
tb/tb_cache_top.sv

// File: run.sh
#!/bin/sh
# build the cache testbench with Verilator, run it, then scan the log
verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module tb_cache_top -o tb_cache_top &&
	./obj_dir/tb_cache_top | tee sim.log &&
	! grep -q "ERRORS FOUND" sim.log &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }

// File: src/buffer_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 2
)(
	input  wire      clock_i,
	input  wire      resetn_i,
	input  wire      push_i,        // dropped while full
	input  wire payload_t push_data_i,
	output logic     full_o,
	input  wire      pop_i,         // ignored while empty
	output payload_t pop_data_o,
	output logic     empty_o
);
	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t            mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0]   count;
	logic                do_push;
	logic                do_pop;

	assign full_o     = (count == DEPTH);
	assign empty_o    = (count == 0);
	assign do_push    = push_i && !full_o;
	assign do_pop     = pop_i && !empty_o;
	assign pop_data_o = mem[rd_ptr];    // head shows without a pop

	// ------------------------------------------------------------------
	// pointers and fill level
	// ------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;                      // both or neither, level holds
			endcase
		end
	end

	always_ff @(posedge clock_i) begin
		if (do_push)
			mem[wr_ptr] <= push_data_i;
	end

endmodule

`default_nettype wire

// File: src/cache_controller.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module cache_controller (
	input  wire                         clock_i,
	input  wire                         resetn_i,
	// core side
	input  wire                         core_req_i,
	input  wire cache_pkg::core_req_t   core_req_data_i,
	output logic                        core_done_o,
	// tag CAM
	input  wire                         cam_hit_i,
	input  wire cache_pkg::line_idx_t   cam_line_i,
	input  wire cache_pkg::tag_t        cam_tag_i,      // victim tag readback
	output logic                        cam_wren_o,
	output cache_pkg::line_idx_t        cam_line_o,
	output cache_pkg::tag_t             cam_tag_o,      // lookup and write tag
	// line RAM
	output logic                        ram_wren_o,
	output cache_pkg::line_idx_t        ram_line_o,
	output cache_pkg::word_idx_t        ram_word_o,
	output mem_pkg::data_t              ram_wdata_o,
	input  wire mem_pkg::data_t         ram_rdata_i,
	// buffers toward memory
	output logic                        cmd_push_o,
	output mem_pkg::mem_cmd_t           cmd_o,
	input  wire                         cmd_full_i,
	output logic                        wbuf_push_o,
	output mem_pkg::data_t              wbuf_data_o,
	input  wire                         wbuf_full_i,
	output logic                        rbuf_pop_o,
	input  wire mem_pkg::data_t         rbuf_data_i,
	input  wire                         rbuf_empty_i,
	output cache_pkg::perf_flags_t      perf_o
);
	import cache_pkg::*;
	import mem_pkg::*;

	typedef enum logic [2:0] {
		ST_NORMAL,              // hit check, replay after a fill
		ST_WAIT_COMMAND,        // queue the block read
		ST_CHOOSE_REPLACEMENT,
		ST_WRITE_BUFFER,        // dirty victim -> write buffer
		ST_READ_BUFFER          // read buffer -> line RAM
	} state_t;

	state_t                     state_reg;
	logic [`CACHE_LINES-1:0]    dirty_reg;
	logic                       req_flag_reg;       // replay pending
	core_req_t                  req_reg;            // missed request
	word_idx_t                  count_reg;          // words moved
	line_idx_t                  repl_ptr_reg;
	logic                       done_reg;
	logic                       wb_pending_reg;     // write command not yet queued
	logic [`WORD_ADDR_BITS-1:0] wb_addr_reg;
	perf_flags_t                perf_reg;

	core_req_t act_req;
	tag_t      act_tag;
	word_idx_t act_word;
	logic      new_req;
	logic      last_word;
	line_idx_t next_ptr;

	assign act_req   = req_flag_reg ? req_reg : core_req_data_i;
	assign act_tag   = act_req.addr[`WORD_ADDR_BITS-1:WORD_BITS];
	assign act_word  = act_req.addr[WORD_BITS-1:0];
	assign new_req   = core_req_i && done_reg;
	assign last_word = (count_reg == word_idx_t'(`BLOCK_WORDS - 1));
	assign next_ptr  = (repl_ptr_reg == line_idx_t'(`CACHE_LINES - 1)) ? '0
	                 : repl_ptr_reg + 1'b1;                 // round robin

	assign core_done_o = done_reg;
	assign perf_o      = perf_reg;

	// ------------------------------------------------------------------
	// CAM, RAM and buffer controls
	// ------------------------------------------------------------------
	always_comb begin
		cam_wren_o  = 1'b0;
		cam_line_o  = repl_ptr_reg;
		cam_tag_o   = act_tag;
		ram_wren_o  = 1'b0;
		ram_line_o  = cam_line_i;           // hit path
		ram_word_o  = act_word;
		ram_wdata_o = act_req.data;
		wbuf_push_o = 1'b0;
		wbuf_data_o = ram_rdata_i;
		rbuf_pop_o  = 1'b0;
		cmd_push_o  = wb_pending_reg && !cmd_full_i;    // writeback goes first
		cmd_o.rw    = 1'b1;
		cmd_o.addr  = wb_addr_reg;
		case (state_reg)
			ST_NORMAL: begin
				if ((new_req || req_flag_reg) && cam_hit_i)
					ram_wren_o = act_req.rw;    // store hit or store replay
			end
			ST_WAIT_COMMAND: begin
				if (!wb_pending_reg && !cmd_full_i) begin
					cmd_push_o = 1'b1;
					cmd_o.rw   = 1'b0;
					cmd_o.addr = {act_tag, {WORD_BITS{1'b0}}};
				end
			end
			ST_CHOOSE_REPLACEMENT: begin
				cam_line_o = next_ptr;          // victim tag ready next cycle
				ram_line_o = next_ptr;          // prime word 0
				ram_word_o = '0;
			end
			ST_WRITE_BUFFER: begin
				ram_line_o  = repl_ptr_reg;
				wbuf_push_o = !wbuf_full_i;
				// read ahead only when the current word leaves
				ram_word_o  = wbuf_push_o ? count_reg + 1'b1 : count_reg;
			end
			ST_READ_BUFFER: begin
				ram_line_o  = repl_ptr_reg;
				ram_word_o  = count_reg;
				ram_wdata_o = rbuf_data_i;
				rbuf_pop_o  = !rbuf_empty_i;
				ram_wren_o  = !rbuf_empty_i;
				cam_wren_o  = !rbuf_empty_i && last_word;   // tag with last word
			end
			default: ;
		endcase
	end

	// ------------------------------------------------------------------
	// state sequencing
	// ------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_reg      <= ST_NORMAL;
			dirty_reg      <= '0;
			req_flag_reg   <= 1'b0;
			count_reg      <= '0;
			repl_ptr_reg   <= line_idx_t'(`CACHE_LINES - 1);   // first fill lands in line 0
			done_reg       <= 1'b1;
			wb_pending_reg <= 1'b0;
			perf_reg       <= '0;
		end else begin
			perf_reg <= '0;
			if (wb_pending_reg && cmd_push_o)
				wb_pending_reg <= 1'b0;
			case (state_reg)
				ST_NORMAL: begin
					if (new_req || req_flag_reg) begin
						if (cam_hit_i) begin
							perf_reg.hit <= !req_flag_reg;
							if (act_req.rw)
								dirty_reg[cam_line_i] <= 1'b1;
							req_flag_reg <= 1'b0;
							done_reg     <= 1'b1;   // replay result shows now
						end else begin
							perf_reg.miss <= 1'b1;
							req_flag_reg  <= 1'b1;
							done_reg      <= 1'b0;  // stall core
							state_reg     <= ST_WAIT_COMMAND;
						end
					end
				end
				ST_WAIT_COMMAND: begin
					if (!wb_pending_reg && !cmd_full_i)
						state_reg <= ST_CHOOSE_REPLACEMENT;
				end
				ST_CHOOSE_REPLACEMENT: begin
					repl_ptr_reg <= next_ptr;
					if (dirty_reg[next_ptr]) begin
						perf_reg.writeback <= 1'b1;
						state_reg          <= ST_WRITE_BUFFER;
					end else begin
						state_reg <= ST_READ_BUFFER;      // clean victim, just overwrite
					end
				end
				ST_WRITE_BUFFER: begin
					if (wbuf_push_o) begin
						count_reg <= last_word ? '0 : count_reg + 1'b1;
						if (last_word) begin
							dirty_reg[repl_ptr_reg] <= 1'b0;
							wb_pending_reg          <= 1'b1;
							state_reg               <= ST_READ_BUFFER;
						end
					end
				end
				ST_READ_BUFFER: begin
					if (rbuf_pop_o) begin
						count_reg <= last_word ? '0 : count_reg + 1'b1;
						if (last_word)
							state_reg <= ST_NORMAL;     // replay from here
					end
				end
				default: state_reg <= ST_NORMAL;
			endcase
		end
	end

	// request and writeback address, payload only
	always_ff @(posedge clock_i) begin
		if ((state_reg == ST_NORMAL) && new_req && !cam_hit_i)
			req_reg <= core_req_data_i;
		if ((state_reg == ST_WRITE_BUFFER) && wbuf_push_o && last_word)
			wb_addr_reg <= {cam_tag_i, {WORD_BITS{1'b0}}};  // victim block base
	end

endmodule

`default_nettype wire

// File: src/cache_line_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module cache_line_ram (
	input  wire                       clock_i,
	input  wire                       wren_i,
	input  wire cache_pkg::line_idx_t line_i,
	input  wire cache_pkg::word_idx_t word_i,
	input  wire mem_pkg::data_t       wdata_i,
	output mem_pkg::data_t            rdata_o
);
	import cache_pkg::*;
	import mem_pkg::*;

	data_t                          mem [`CACHE_LINES * `BLOCK_WORDS];
	logic [LINE_BITS+WORD_BITS-1:0] addr;

	assign addr = {line_i, word_i};     // line major, words of a block adjacent

	// registered read, old data on a same cycle write
	always_ff @(posedge clock_i) begin
		if (wren_i)
			mem[addr] <= wdata_i;
		rdata_o <= mem[addr];
	end

endmodule

`default_nettype wire

// File: src/cache_pkg.sv
`default_nettype none
`include "cache_settings.svh"

package cache_pkg;

	localparam int LINE_BITS = $clog2(`CACHE_LINES);
	localparam int WORD_BITS = $clog2(`BLOCK_WORDS);
	localparam int TAG_BITS  = `WORD_ADDR_BITS - WORD_BITS;   // no set bits

	typedef logic [LINE_BITS-1:0] line_idx_t;   // cache line number
	typedef logic [WORD_BITS-1:0] word_idx_t;   // word within a line
	typedef logic [TAG_BITS-1:0]  tag_t;

	// core request, sampled with core_req_i
	typedef struct packed {
		logic                       rw;     // 1 = store
		logic [`WORD_ADDR_BITS-1:0] addr;
		logic [`DATA_BITS-1:0]      data;   // store data
	} core_req_t;

	// single cycle event pulses
	typedef struct packed {
		logic hit;          // initial reference hit
		logic miss;
		logic writeback;    // dirty victim chosen
	} perf_flags_t;

endpackage

`default_nettype wire

// File: src/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// cache geometry
`define CACHE_LINES     8       // fully associative, one set
`define BLOCK_WORDS     4       // words per line

// core address and data
`define WORD_ADDR_BITS  16      // word address, not byte
`define DATA_BITS       32

// buffers toward memory
`define CMD_DEPTH       2
`define DATA_DEPTH      `BLOCK_WORDS    // one whole block each way

`endif

// File: src/cache_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module cache_top (
	input  wire                       clock_i,
	input  wire                       resetn_i,
	// core side
	input  wire                       core_req_i,
	input  wire cache_pkg::core_req_t core_req_data_i,
	output logic                      core_done_o,
	output mem_pkg::data_t            core_data_o,
	// memory side
	input  wire                       mem_ready_i,
	output logic                      mem_cmd_valid_o,
	output mem_pkg::mem_cmd_t         mem_cmd_o,
	output logic                      mem_wdata_valid_o,
	output mem_pkg::data_t            mem_wdata_o,
	input  wire                       mem_wdata_ack_i,
	input  wire                       mem_rdata_valid_i,
	input  wire mem_pkg::data_t       mem_rdata_i,
	// events
	output cache_pkg::perf_flags_t    perf_o
);
	import cache_pkg::*;
	import mem_pkg::*;

	// ------------------------------------------------------------------
	// internal wiring
	// ------------------------------------------------------------------
	logic      cam_hit, cam_wren;
	line_idx_t cam_hit_line, cam_line;
	tag_t      cam_rd_tag, cam_tag;

	logic      ram_wren;
	line_idx_t ram_line;
	word_idx_t ram_word;
	data_t     ram_wdata, ram_rdata;

	logic      cmd_push, cmd_full, cmd_empty;
	mem_cmd_t  cmd_data;
	logic      wbuf_push, wbuf_full, wbuf_empty;
	data_t     wbuf_data;
	logic      rbuf_pop, rbuf_empty;
	data_t     rbuf_data;

	assign core_data_o       = ram_rdata;     // loads come straight off the RAM
	assign mem_cmd_valid_o   = !cmd_empty;
	assign mem_wdata_valid_o = !wbuf_empty;

	cache_controller controller (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.core_req_i(core_req_i), .core_req_data_i(core_req_data_i), .core_done_o(core_done_o),
		.cam_hit_i(cam_hit), .cam_line_i(cam_hit_line), .cam_tag_i(cam_rd_tag),
		.cam_wren_o(cam_wren), .cam_line_o(cam_line), .cam_tag_o(cam_tag),
		.ram_wren_o(ram_wren), .ram_line_o(ram_line), .ram_word_o(ram_word),
		.ram_wdata_o(ram_wdata), .ram_rdata_i(ram_rdata),
		.cmd_push_o(cmd_push), .cmd_o(cmd_data), .cmd_full_i(cmd_full),
		.wbuf_push_o(wbuf_push), .wbuf_data_o(wbuf_data), .wbuf_full_i(wbuf_full),
		.rbuf_pop_o(rbuf_pop), .rbuf_data_i(rbuf_data), .rbuf_empty_i(rbuf_empty),
		.perf_o(perf_o)
	);

	// one tag drives lookup and write, one line drives write and readback
	tag_cam cam (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.lookup_tag_i(cam_tag), .hit_o(cam_hit), .hit_line_o(cam_hit_line),
		.wren_i(cam_wren), .wr_line_i(cam_line), .wr_tag_i(cam_tag),
		.rd_line_i(cam_line), .rd_tag_o(cam_rd_tag)
	);

	cache_line_ram ram (
		.clock_i(clock_i), .wren_i(ram_wren), .line_i(ram_line), .word_i(ram_word),
		.wdata_i(ram_wdata), .rdata_o(ram_rdata)
	);

	// ------------------------------------------------------------------
	// buffers toward memory
	// ------------------------------------------------------------------
	buffer_fifo #(.payload_t(mem_cmd_t), .DEPTH(`CMD_DEPTH)) cmd_fifo (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.push_i(cmd_push), .push_data_i(cmd_data), .full_o(cmd_full),
		.pop_i(mem_ready_i), .pop_data_o(mem_cmd_o), .empty_o(cmd_empty)
	);

	buffer_fifo #(.payload_t(data_t), .DEPTH(`DATA_DEPTH)) wdata_fifo (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.push_i(wbuf_push), .push_data_i(wbuf_data), .full_o(wbuf_full),
		.pop_i(mem_wdata_ack_i), .pop_data_o(mem_wdata_o), .empty_o(wbuf_empty)
	);

	// one read outstanding at a time, a block always fits
	buffer_fifo #(.payload_t(data_t), .DEPTH(`DATA_DEPTH)) rdata_fifo (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.push_i(mem_rdata_valid_i), .push_data_i(mem_rdata_i), .full_o(),
		.pop_i(rbuf_pop), .pop_data_o(rbuf_data), .empty_o(rbuf_empty)
	);

endmodule

`default_nettype wire

// File: src/mem_pkg.sv
`default_nettype none
`include "cache_settings.svh"

package mem_pkg;

	// one word on the memory data paths
	typedef logic [`DATA_BITS-1:0] data_t;

	// block command toward memory
	// a read returns BLOCK_WORDS words, a write takes as many from the write buffer
	typedef struct packed {
		logic                       rw;     // 1 = block write
		logic [`WORD_ADDR_BITS-1:0] addr;   // block base, word bits zero
	} mem_cmd_t;

endpackage

`default_nettype wire

// File: src/tag_cam.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module tag_cam (
	input  wire                  clock_i,
	input  wire                  resetn_i,
	// associative lookup
	input  wire cache_pkg::tag_t lookup_tag_i,
	output logic                 hit_o,
	output cache_pkg::line_idx_t hit_line_o,
	// tag write on fill
	input  wire                  wren_i,
	input  wire cache_pkg::line_idx_t wr_line_i,
	input  wire cache_pkg::tag_t wr_tag_i,
	// victim tag readback
	input  wire cache_pkg::line_idx_t rd_line_i,
	output cache_pkg::tag_t      rd_tag_o
);
	import cache_pkg::*;

	tag_t                    tags [`CACHE_LINES];
	logic [`CACHE_LINES-1:0] valid;

	// match against every line at once, at most one can hit
	always_comb begin
		hit_o      = 1'b0;
		hit_line_o = '0;
		for (int i = 0; i < `CACHE_LINES; i++) begin
			if (valid[i] && (tags[i] == lookup_tag_i)) begin
				hit_o      = 1'b1;
				hit_line_o = line_idx_t'(i);
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			valid <= '0;                    // empty cache
		else if (wren_i)
			valid[wr_line_i] <= 1'b1;
	end

	always_ff @(posedge clock_i) begin
		if (wren_i)
			tags[wr_line_i] <= wr_tag_i;
		rd_tag_o <= tags[rd_line_i];        // one cycle readback
	end

endmodule

`default_nettype wire

// File: tb/cache_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module cache_checker (
	input  wire                         clock_i,
	input  wire                         resetn_i,
	// core side, as seen at the DUT
	input  wire                         core_req_i,
	input  wire cache_pkg::core_req_t   core_req_data_i,
	input  wire                         core_done_i,
	input  wire mem_pkg::data_t         core_data_i,
	// memory side
	input  wire                         mem_ready_i,
	input  wire                         mem_cmd_valid_i,
	input  wire mem_pkg::mem_cmd_t      mem_cmd_i,
	input  wire                         mem_wdata_valid_i,
	input  wire mem_pkg::data_t         mem_wdata_i,
	input  wire                         mem_wdata_ack_i,
	input  wire cache_pkg::perf_flags_t perf_i,
	// results
	output int                          checks_o,
	output int                          errors_o,
	output int                          leftover_o      // expected traffic not seen yet
);
	import cache_pkg::*;
	import mem_pkg::*;

	data_t                   ref_mem [2**`WORD_ADDR_BITS];   // architectural memory
	tag_t                    line_tag [`CACHE_LINES];        // resident blocks
	logic [`CACHE_LINES-1:0] line_valid;
	logic [`CACHE_LINES-1:0] line_dirty;
	line_idx_t               repl_ptr;
	mem_cmd_t                exp_cmd_q [$];
	data_t                   exp_wdata_q [$];
	core_req_t               req;                            // request in flight
	logic                    pending;
	logic                    first_cycle;
	logic                    started;                        // first request seen
	logic                    exp_hit;
	logic                    exp_wb;
	logic                    saw_wb;
	int                      checks = 0;
	int                      errors = 0;
	int                      leftover = 0;

	assign checks_o   = checks;
	assign errors_o   = errors;
	assign leftover_o = leftover;

	// power-up contents, every address bit shows up
	function automatic data_t fill_word(input logic [`WORD_ADDR_BITS-1:0] a);
		return {a ^ 16'h3c5a, ~a};
	endfunction

	task automatic compare_value(input logic [47:0] got, input logic [47:0] exp,
	                             input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// ------------------------------------------------------------------
	// cache model: residency, dirty lines, round robin victim
	// ------------------------------------------------------------------
	task automatic predict_access(input logic [`WORD_ADDR_BITS-1:0] addr, input logic store);
		tag_t      blk;
		line_idx_t line;
		blk     = addr[`WORD_ADDR_BITS-1:WORD_BITS];
		exp_hit = 1'b0;
		exp_wb  = 1'b0;
		line    = '0;
		for (int i = 0; i < `CACHE_LINES; i++) begin
			if (line_valid[i] && (line_tag[i] == blk)) begin
				exp_hit = 1'b1;
				line    = line_idx_t'(i);
			end
		end
		if (!exp_hit) begin
			repl_ptr = line_idx_t'((int'(repl_ptr) + 1) % `CACHE_LINES);   // next line, wraps
			line     = repl_ptr;
			exp_cmd_q.push_back({1'b0, blk, {WORD_BITS{1'b0}}});           // fetch first
			if (line_valid[line] && line_dirty[line]) begin
				exp_wb = 1'b1;
				exp_cmd_q.push_back({1'b1, line_tag[line], {WORD_BITS{1'b0}}});
				for (int w = 0; w < `BLOCK_WORDS; w++)
					exp_wdata_q.push_back(ref_mem[{line_tag[line], word_idx_t'(w)}]);
			end
			line_tag[line]   = blk;
			line_valid[line] = 1'b1;
			line_dirty[line] = 1'b0;
		end
		if (store)
			line_dirty[line] = 1'b1;
	endtask

	initial begin
		for (int a = 0; a < 2**`WORD_ADDR_BITS; a++)
			ref_mem[a] = fill_word(16'(a));
	end

	// ------------------------------------------------------------------
	// sampled mid cycle, all DUT outputs settled
	// ------------------------------------------------------------------
	always @(negedge clock_i) begin
		if (!resetn_i) begin
			line_valid  = '0;
			line_dirty  = '0;
			repl_ptr    = line_idx_t'(`CACHE_LINES - 1);
			pending     = 1'b0;
			first_cycle = 1'b0;
			started     = 1'b0;
			saw_wb      = 1'b0;
			exp_cmd_q.delete();
			exp_wdata_q.delete();
		end else begin
			if (!started) begin     // at rest after reset
				compare_value(48'(core_done_i), 48'(1), "core_done_o at rest");
				compare_value(48'({mem_cmd_valid_i, mem_wdata_valid_i, perf_i}), 48'(0),
				              "valids and perf_o at rest");
			end
			if (perf_i.writeback)
				saw_wb = 1'b1;
			if (pending && first_cycle) begin
				compare_value(48'({perf_i.hit, perf_i.miss}), 48'({exp_hit, !exp_hit}),
				              "hit and miss pulses");
				compare_value(48'(core_done_i), 48'(exp_hit), "core_done_o after request");
				first_cycle = 1'b0;
			end else if (started) begin     // only the initial reference pulses
				compare_value(48'({perf_i.hit, perf_i.miss}), 48'(0),
				              "hit and miss pulses outside a request");
			end
			if (pending && core_done_i) begin       // result visible now
				if (!req.rw)
					compare_value(48'(core_data_i), 48'(ref_mem[req.addr]), "load data");
				else
					ref_mem[req.addr] = req.data;
				compare_value(48'(saw_wb), 48'(exp_wb), "writeback pulse");
				pending = 1'b0;
			end
			if (mem_cmd_valid_i && mem_ready_i) begin
				if (exp_cmd_q.size() == 0) begin
					errors++;
					$display("memory command %0h was issued with none expected", mem_cmd_i);
				end else begin
					compare_value(48'(mem_cmd_i), 48'(exp_cmd_q.pop_front()), "memory command");
				end
			end
			if (mem_wdata_valid_i && mem_wdata_ack_i) begin
				if (exp_wdata_q.size() == 0) begin
					errors++;
					$display("write data %0h was sent with no writeback expected", mem_wdata_i);
				end else begin
					compare_value(48'(mem_wdata_i), 48'(exp_wdata_q.pop_front()), "write data");
				end
			end
			if (core_req_i && core_done_i) begin    // taken at the next edge
				started     = 1'b1;
				req         = core_req_data_i;
				pending     = 1'b1;
				first_cycle = 1'b1;
				saw_wb      = 1'b0;
				predict_access(core_req_data_i.addr, core_req_data_i.rw);
			end
			leftover = exp_cmd_q.size() + exp_wdata_q.size();
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_cache_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module tb_cache_top;
	import cache_pkg::*;
	import mem_pkg::*;

	localparam int TEST_BLOCKS = 24;    // three blocks per line, forces evictions
	localparam int WAIT_LIMIT  = 2000;  // cycles per wait

	logic        clock;
	logic        resetn;
	logic        core_req;
	core_req_t   core_req_data;
	logic        core_done;
	data_t       core_data;
	logic        mem_ready;
	logic        mem_cmd_valid;
	mem_cmd_t    mem_cmd;
	logic        mem_wdata_valid;
	data_t       mem_wdata;
	logic        mem_wdata_ack;
	logic        mem_rdata_valid;
	data_t       mem_rdata;
	perf_flags_t perf;
	int          checks;
	int          errors;
	int          leftover;
	data_t       backing [2**`WORD_ADDR_BITS];  // memory behind the cache
	mem_cmd_t    cmd_q [$];                     // accepted, not yet served
	logic        stall_mode = 1'b0;             // random mem_ready drops
	logic        timed_out = 1'b0;

	cache_top uut (
		.clock_i(clock), .resetn_i(resetn),
		.core_req_i(core_req), .core_req_data_i(core_req_data),
		.core_done_o(core_done), .core_data_o(core_data),
		.mem_ready_i(mem_ready), .mem_cmd_valid_o(mem_cmd_valid), .mem_cmd_o(mem_cmd),
		.mem_wdata_valid_o(mem_wdata_valid), .mem_wdata_o(mem_wdata),
		.mem_wdata_ack_i(mem_wdata_ack),
		.mem_rdata_valid_i(mem_rdata_valid), .mem_rdata_i(mem_rdata),
		.perf_o(perf)
	);

	cache_checker chk (
		.clock_i(clock), .resetn_i(resetn),
		.core_req_i(core_req), .core_req_data_i(core_req_data),
		.core_done_i(core_done), .core_data_i(core_data),
		.mem_ready_i(mem_ready), .mem_cmd_valid_i(mem_cmd_valid), .mem_cmd_i(mem_cmd),
		.mem_wdata_valid_i(mem_wdata_valid), .mem_wdata_i(mem_wdata),
		.mem_wdata_ack_i(mem_wdata_ack), .perf_i(perf),
		.checks_o(checks), .errors_o(errors), .leftover_o(leftover)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;  // 10 ns
	end

	// power-up contents, every address bit shows up
	function automatic data_t fill_word(input logic [`WORD_ADDR_BITS-1:0] a);
		return {a ^ 16'h3c5a, ~a};
	endfunction

	// test blocks spread over the address space
	function automatic logic [`WORD_ADDR_BITS-1:0] block_base(input int unsigned blk);
		return 16'h4000 + 16'(blk) * 16'h0214;
	endfunction

	// ------------------------------------------------------------------
	// memory model, serves commands in order
	// ------------------------------------------------------------------
	always @(negedge clock)
		if (resetn && mem_cmd_valid && mem_ready)
			cmd_q.push_back(mem_cmd);   // leaves the DUT at the next edge

	initial begin : memory_model
		int beat;
		int stretch;
		beat            = 0;
		stretch         = 0;
		mem_ready       = 1'b1;
		mem_wdata_ack   = 1'b0;
		mem_rdata_valid = 1'b0;
		mem_rdata       = '0;
		for (int a = 0; a < 2**`WORD_ADDR_BITS; a++)
			backing[a] = fill_word(16'(a));
		forever begin
			@(posedge clock);
			#1;
			mem_wdata_ack   = 1'b0;
			mem_rdata_valid = 1'b0;
			if (stretch > 0) begin
				stretch--;
			end else begin
				mem_ready = stall_mode ? 1'($urandom_range(1)) : 1'b1;
				stretch   = $urandom_range(7);              // hold level a while
			end
			if ((cmd_q.size() != 0) && ($urandom_range(2) != 0)) begin    // random beat gaps
				if (!cmd_q[0].rw) begin
					mem_rdata_valid = 1'b1;
					mem_rdata       = backing[cmd_q[0].addr + 16'(beat)];
					beat++;
				end else if (mem_wdata_valid) begin
					mem_wdata_ack                        = 1'b1;
					backing[cmd_q[0].addr + 16'(beat)] = mem_wdata;
					beat++;
				end
				if (beat == `BLOCK_WORDS) begin
					beat = 0;
					cmd_q.delete(0);
				end
			end
		end
	end

	// core idle, optionally with the memory side drained too
	task automatic wait_until_ready(input logic drain, input string what);
		int cycles;
		cycles = 0;
		while (!timed_out && !(core_done && (!drain ||
		       ((cmd_q.size() == 0) && !mem_cmd_valid && !mem_wdata_valid))))
		begin
			@(posedge clock);
			#1;
			cycles++;
			if (cycles == WAIT_LIMIT) begin
				timed_out = 1'b1;
				$display("timeout: no %s within %0d cycles", what, WAIT_LIMIT);
			end
		end
	endtask

	task automatic run_test(input string name, input logic stalls, input int count);
		int        errors_before;
		core_req_t req;
		errors_before = errors;
		stall_mode    = stalls;
		for (int n = 0; (n < count) && !timed_out; n++) begin
			wait_until_ready(1'b0, "core_done_o");
			req.rw        = 1'($urandom_range(1));
			req.addr      = block_base($urandom_range(TEST_BLOCKS - 1))
			              + 16'($urandom_range(`BLOCK_WORDS - 1));
			req.data      = $urandom;
			core_req_data = req;
			core_req      = 1'b1;
			@(posedge clock);
			#1;
			core_req = 1'b0;
			repeat ($urandom_range(2)) begin        // sometimes back to back
				@(posedge clock);
				#1;
			end
		end
		wait_until_ready(1'b1, "idle memory side");
		$display("test %s: %0d requests, %0d errors", name, count, errors - errors_before);
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------
	initial begin : stimulus
		void'($urandom(32'hb88a));              // seed the generator
		resetn        = 1'b0;
		core_req      = 1'b0;
		core_req_data = '0;
		repeat (3) @(posedge clock);
		#1;
		resetn = 1'b1;
		repeat (4) @(posedge clock);            // outputs watched at rest
		#1;
		run_test("hit_miss_fill", 1'b0, 400);
		if (!timed_out)
			run_test("ready_stalls", 1'b1, 400);
		$display("totals: %0d checks, %0d errors, %0d expected transfers missing",
		         checks, errors, leftover);
		if (timed_out || (errors != 0) || (leftover != 0))
			$display("ERRORS FOUND");
		else
			$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire
